//--- project.f
+incdir+tests
verilog/hub_desc_pkg.sv
verilog/sched_msg_pkg.sv
verilog/desc_fifo.sv
verilog/core_desc_sorter.sv
verilog/sched_msg_parser.sv
verilog/desc_out_stage.sv
verilog/core_desc_hub.sv
tests/core_desc_hub_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the descriptor hub regression with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module core_desc_hub_tb -Mdir obj_dir \
  && ./obj_dir/Vcore_desc_hub_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && echo "Simulation OK" \
  || { echo "Simulation FAILED"; exit 1; }

//--- tests/hub_ref_model.svh
/* Descriptor hub reference model
   Expected output queues and a mirror of the parser slot table */
`ifndef HUB_REF_MODEL_SVH
`define HUB_REF_MODEL_SVH

desc_t                 data_exp [$];
desc_t                 sched_exp [$];
int                    sched_due [$];
sched_word_t           ctrl_exp [$];
logic [64:0]           dram_exp [$];
logic [ADDR_WIDTH-1:0] slot_addr_m [1:SLOT_COUNT];
logic [15:0]           slot_len_m [1:SLOT_COUNT];

function automatic void init_slot_mirror();
  for (int i = 1; i <= SLOT_COUNT; i++) begin
    slot_addr_m[i] = ADDR_WIDTH'(SLOT_START_ADDR + (i - 1) * SLOT_ADDR_STEP);
    slot_len_m[i]  = '0;
  end
endfunction

// Core reset drops everything still queued
function automatic void flush_expected();
  data_exp.delete();
  sched_exp.delete();
  sched_due.delete();
  dram_exp.delete();
endfunction

function automatic void expect_core_desc(desc_t d, logic [63:0] addr);
  logic [3:0] op;
  int         slot;
  op = d[63:60];
  if (op == 4'd0) begin
    data_exp.push_back(d);
  end else if (op >= 4'd1 && op <= 4'd3) begin
    ctrl_exp.push_back({op, d[31:0]});
    slot = d[19:16];
    slot_addr_m[slot] = d[32 +: ADDR_WIDTH];
    slot_len_m[slot]  = d[15:0];
  end else if (op == 4'd5) begin
    dram_exp.push_back({1'b0, d});
    dram_exp.push_back({1'b1, addr});
  end
endfunction

// Parsed descriptor reaches the FIFO head two cycles after acceptance
function automatic void expect_sched_msg(sched_word_t msg, int cyc);
  int          slot;
  logic [31:0] addr;
  slot = msg[19:16];
  addr = 32'(slot_addr_m[slot]);
  if (msg[35:32] == 4'd1) begin
    sched_exp.push_back({addr, msg[31:16], slot_len_m[slot]});
  end else begin
    sched_exp.push_back({addr, msg[31:0]});
  end
  sched_due.push_back(cyc + 2);
endfunction

`endif

//--- tests/core_desc_hub_tb.sv
/* Descriptor hub testbench
   Random core and scheduler traffic checked against a reference model */
module core_desc_hub_tb
  import hub_desc_pkg::*;
  import sched_msg_pkg::*;
;
  localparam int ADDR_WIDTH      = 22;
  localparam int SLOT_COUNT      = 8;
  localparam int SLOT_START_ADDR = 0;
  localparam int SLOT_ADDR_STEP  = 16384;

  logic        sys_clk;
  logic        sys_rst;
  desc_t       core_desc;
  logic [63:0] core_dram_addr;
  logic        core_desc_valid;
  logic        core_desc_ready;
  sched_word_t ctrl_s_tdata;
  logic        ctrl_s_tvalid;
  logic        ctrl_s_tready;
  sched_word_t ctrl_m_tdata;
  logic        ctrl_m_tvalid;
  logic        ctrl_m_tready;
  desc_t       send_desc;
  logic        send_desc_valid;
  logic        send_desc_ready;
  logic [63:0] dram_m_tdata;
  logic        dram_m_tvalid;
  logic        dram_m_tready;
  logic        dram_m_tlast;
  logic        core_reset;

  desc_t       core_src [$];
  logic [63:0] core_src_addr [$];
  sched_word_t sched_src [$];
  logic [31:0] rng_state = 32'd12;
  int          cyc = 0;
  int          issued = 0;
  logic        hold_out = 1'b0;
  logic        reset_m = 1'b1;
  logic        reset_next = 1'b1;
  string       cur_test = "reset";

  `include "hub_ref_model.svh"

  core_desc_hub #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .SLOT_COUNT     (SLOT_COUNT),
    .SLOT_START_ADDR(SLOT_START_ADDR),
    .SLOT_ADDR_STEP (SLOT_ADDR_STEP)
  ) core_desc_hub_i (.*);

  initial begin
    sys_clk = 1'b0;
    forever #2 sys_clk = ~sys_clk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_desc(desc_t exp, desc_t act);
    if (exp !== act) begin
      fail_run($sformatf("Error %s send expected %h actual %h", cur_test, exp, act));
    end
  endtask

  task automatic check_sched_word(sched_word_t exp, sched_word_t act);
    if (exp !== act) begin
      fail_run($sformatf("Error %s ctrl expected %h actual %h", cur_test, exp, act));
    end
  endtask

  task automatic check_dram_beat(logic [64:0] exp, logic [64:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Error %s dram expected %h actual %h", cur_test, exp, act));
    end
  endtask

  task automatic check_core_reset(logic exp, logic act);
    if (exp !== act) begin
      fail_run($sformatf("Error %s core_reset expected %b actual %b", cur_test, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Drive on the falling edge then check what the next edge takes
  ////////////////////////////////////////////////////////////////////////////
  task automatic step();
    logic [31:0] r;
    @(negedge sys_clk);
    cyc++;
    if (cyc > 40 * issued + 200) begin
      fail_run("Timeout, the DUT stopped moving descriptors");
    end
    reset_m = reset_next;
    r = next_rand();
    send_desc_ready = !hold_out && (r[20] || r[21]);
    ctrl_m_tready   = !hold_out && (r[22] || r[23]);
    dram_m_tready   = !hold_out && r[24];
    core_desc_valid = (core_src.size() > 0);
    core_desc       = core_desc_valid ? core_src[0] : '0;
    core_dram_addr  = core_desc_valid ? core_src_addr[0] : '0;
    ctrl_s_tvalid   = (sched_src.size() > 0);
    ctrl_s_tdata    = ctrl_s_tvalid ? sched_src[0] : '0;
    #1;
    if (sys_rst) begin
      return;
    end
    check_core_reset(reset_m, core_reset);
    if (reset_m && (core_desc_ready || send_desc_valid || dram_m_tvalid || ctrl_m_tvalid)) begin
      fail_run("Hub is active while the core is held in reset");
    end
    if (send_desc_valid && send_desc_ready) begin
      if (sched_exp.size() > 0 && sched_due[0] <= cyc) begin
        check_desc(sched_exp.pop_front(), send_desc);
        void'(sched_due.pop_front());
      end else if (data_exp.size() > 0) begin
        check_desc(data_exp.pop_front(), send_desc);
      end else begin
        fail_run("Send descriptor came out that was never expected");
      end
    end
    if (ctrl_m_tvalid && ctrl_m_tready) begin
      if (ctrl_exp.size() == 0) begin
        fail_run("Scheduler output word came out that was never expected");
      end
      check_sched_word(ctrl_exp.pop_front(), ctrl_m_tdata);
    end
    if (dram_m_tvalid && dram_m_tready) begin
      if (dram_exp.size() == 0) begin
        fail_run("DRAM beat came out that was never expected");
      end
      check_dram_beat(dram_exp.pop_front(), {dram_m_tlast, dram_m_tdata});
    end
    if (core_desc_valid && core_desc_ready) begin
      expect_core_desc(core_src.pop_front(), core_src_addr.pop_front());
    end
    if (ctrl_s_tvalid && ctrl_s_tready) begin
      if (sched_src[0][35:32] == 4'd15) begin
        reset_next = sched_src[0][0];
        if (sched_src[0][0]) begin
          flush_expected();
        end
      end else begin
        expect_sched_msg(sched_src[0], cyc);
      end
      void'(sched_src.pop_front());
    end
  endtask

  task automatic drain();
    while (core_src.size() + sched_src.size() + data_exp.size() + sched_exp.size() +
           ctrl_exp.size() + dram_exp.size() > 0) begin
      step();
    end
  endtask

  // Random core descriptor with the given opcode and a legal slot
  task automatic add_core(logic [3:0] op);
    desc_t d;
    d = {next_rand(), next_rand()};
    d[63:60] = op;
    d[19:16] = 4'(next_rand() % SLOT_COUNT + 1);
    core_src.push_back(d);
    core_src_addr.push_back({next_rand(), next_rand()});
    issued++;
  endtask

  task automatic add_sched(logic [3:0] msg_type, logic [31:0] body);
    sched_src.push_back({msg_type, body});
    issued++;
  endtask

  task automatic add_sched_random();
    logic [31:0] body;
    logic [3:0]  t;
    body = next_rand();
    body[19:16] = 4'(next_rand() % SLOT_COUNT + 1);
    t = next_rand() % 2 ? 4'd1 : 4'(next_rand() % 13 + 2);
    add_sched(t, body);
  endtask

  initial begin
    sys_rst = 1'b1;
    core_desc_valid = 1'b0;
    core_desc = '0;
    core_dram_addr = '0;
    ctrl_s_tvalid = 1'b0;
    ctrl_s_tdata = '0;
    ctrl_m_tready = 1'b0;
    send_desc_ready = 1'b0;
    dram_m_tready = 1'b0;
    init_slot_mirror();
    repeat (3) step();
    @(negedge sys_clk);
    sys_rst = 1'b0;
    // Descriptor waits while the core is held in reset
    add_core(4'd0);
    repeat (6) step();
    if (core_src.size() != 1) begin
      fail_run("Core descriptor was taken while the core was held in reset");
    end
    add_sched(4'd15, 32'd0);
    drain();

    cur_test = "data";
    repeat (20) add_core(4'd0);
    drain();

    cur_test = "ctrl";
    for (int i = 0; i < 12; i++) add_core(4'(next_rand() % 3 + 1));
    drain();

    cur_test = "sched";
    repeat (16) add_sched_random();
    drain();

    cur_test = "merge";
    for (int i = 0; i < 16; i++) begin
      add_sched_random();
      add_core(4'd0);
    end
    drain();

    cur_test = "dram";
    for (int i = 0; i < 12; i++) add_core(i % 3 == 2 ? 4'd4 : 4'd5);
    drain();

    cur_test = "flush";
    hold_out = 1'b1;
    repeat (3) add_core(4'd0);
    repeat (2) add_core(4'd5);
    while (core_src.size() > 0) step();
    add_sched(4'd15, 32'd1);
    add_sched(4'd15, 32'd0);
    while (sched_src.size() > 0) step();
    hold_out = 1'b0;
    repeat (10) step();
    drain();

    // Every output is idle once the last transfers have landed
    step();
    if (send_desc_valid || ctrl_m_tvalid || dram_m_tvalid) begin
      fail_run("An output is still valid after every expected descriptor came out");
    end else begin
      $display("Regression passed");
    end
    $finish;
  end

endmodule

//--- verilog/core_desc_hub.sv
/* Descriptor hub top
   Joins the core sorter, scheduler parser and output stage */
module core_desc_hub
  import hub_desc_pkg::*;
  import sched_msg_pkg::*;
#(
  parameter int ADDR_WIDTH      = 22,
  parameter int SLOT_COUNT      = 8,
  parameter int DESC_DEPTH      = 8,
  parameter int SLOT_START_ADDR = 0,
  parameter int SLOT_ADDR_STEP  = 16384
) (
  input  logic        sys_clk,
  input  logic        sys_rst,
  input  desc_t       core_desc,
  input  logic [63:0] core_dram_addr,
  input  logic        core_desc_valid,
  output logic        core_desc_ready,
  input  sched_word_t ctrl_s_tdata,
  input  logic        ctrl_s_tvalid,
  output logic        ctrl_s_tready,
  output sched_word_t ctrl_m_tdata,
  output logic        ctrl_m_tvalid,
  input  logic        ctrl_m_tready,
  output desc_t       send_desc,
  output logic        send_desc_valid,
  input  logic        send_desc_ready,
  output logic [63:0] dram_m_tdata,
  output logic        dram_m_tvalid,
  input  logic        dram_m_tready,
  output logic        dram_m_tlast,
  output logic        core_reset
);

  localparam int SLOT_WIDTH = $clog2(SLOT_COUNT + 1);

  desc_t                 data_head;
  logic                  data_valid;
  logic                  data_pop;
  desc_t                 ctrl_head;
  logic                  ctrl_valid;
  logic                  ctrl_pop;
  logic [127:0]          dram_rd_head;
  logic                  dram_rd_valid;
  logic                  dram_rd_pop;
  desc_t                 sched_desc;
  logic                  sched_desc_valid;
  logic                  sched_desc_ready;
  logic                  slot_wr_valid;
  logic [SLOT_WIDTH-1:0] slot_wr_ptr;
  logic [ADDR_WIDTH-1:0] slot_wr_addr;
  logic [15:0]           slot_wr_len;

  core_desc_sorter #(.DESC_DEPTH(DESC_DEPTH)) core_desc_sorter_i (
    .sys_clk        (sys_clk),
    .sys_rst        (sys_rst),
    .core_reset     (core_reset),
    .core_desc      (core_desc),
    .core_dram_addr (core_dram_addr),
    .core_desc_valid(core_desc_valid),
    .core_desc_ready(core_desc_ready),
    .data_head      (data_head),
    .data_valid     (data_valid),
    .data_pop       (data_pop),
    .ctrl_head      (ctrl_head),
    .ctrl_valid     (ctrl_valid),
    .ctrl_pop       (ctrl_pop),
    .dram_rd_head   (dram_rd_head),
    .dram_rd_valid  (dram_rd_valid),
    .dram_rd_pop    (dram_rd_pop)
  );

  sched_msg_parser #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .SLOT_COUNT     (SLOT_COUNT),
    .DESC_DEPTH     (DESC_DEPTH),
    .SLOT_START_ADDR(SLOT_START_ADDR),
    .SLOT_ADDR_STEP (SLOT_ADDR_STEP),
    .SLOT_WIDTH     (SLOT_WIDTH)
  ) sched_msg_parser_i (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .ctrl_s_tdata    (ctrl_s_tdata),
    .ctrl_s_tvalid   (ctrl_s_tvalid),
    .ctrl_s_tready   (ctrl_s_tready),
    .core_reset      (core_reset),
    .slot_wr_valid   (slot_wr_valid),
    .slot_wr_ptr     (slot_wr_ptr),
    .slot_wr_addr    (slot_wr_addr),
    .slot_wr_len     (slot_wr_len),
    .sched_desc      (sched_desc),
    .sched_desc_valid(sched_desc_valid),
    .sched_desc_ready(sched_desc_ready)
  );

  desc_out_stage #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .SLOT_COUNT(SLOT_COUNT),
    .SLOT_WIDTH(SLOT_WIDTH)
  ) desc_out_stage_i (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .data_head       (data_head),
    .data_valid      (data_valid),
    .data_pop        (data_pop),
    .ctrl_head       (ctrl_head),
    .ctrl_valid      (ctrl_valid),
    .ctrl_pop        (ctrl_pop),
    .dram_rd_head    (dram_rd_head),
    .dram_rd_valid   (dram_rd_valid),
    .dram_rd_pop     (dram_rd_pop),
    .sched_desc      (sched_desc),
    .sched_desc_valid(sched_desc_valid),
    .sched_desc_ready(sched_desc_ready),
    .slot_wr_valid   (slot_wr_valid),
    .slot_wr_ptr     (slot_wr_ptr),
    .slot_wr_addr    (slot_wr_addr),
    .slot_wr_len     (slot_wr_len),
    .send_desc       (send_desc),
    .send_desc_valid (send_desc_valid),
    .send_desc_ready (send_desc_ready),
    .ctrl_m_tdata    (ctrl_m_tdata),
    .ctrl_m_tvalid   (ctrl_m_tvalid),
    .ctrl_m_tready   (ctrl_m_tready),
    .dram_m_tdata    (dram_m_tdata),
    .dram_m_tvalid   (dram_m_tvalid),
    .dram_m_tready   (dram_m_tready),
    .dram_m_tlast    (dram_m_tlast)
  );

endmodule

//--- verilog/desc_out_stage.sv
/* Descriptor output stage
   Send arbiter, registered scheduler output and DRAM-read serializer */
module desc_out_stage
  import hub_desc_pkg::*;
  import sched_msg_pkg::*;
#(
  parameter int ADDR_WIDTH = 22,
  parameter int SLOT_COUNT = 8,
  parameter int SLOT_WIDTH = $clog2(SLOT_COUNT + 1)
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  desc_t                 data_head,
  input  logic                  data_valid,
  output logic                  data_pop,
  input  desc_t                 ctrl_head,
  input  logic                  ctrl_valid,
  output logic                  ctrl_pop,
  input  logic [127:0]          dram_rd_head,
  input  logic                  dram_rd_valid,
  output logic                  dram_rd_pop,
  input  desc_t                 sched_desc,
  input  logic                  sched_desc_valid,
  output logic                  sched_desc_ready,
  output logic                  slot_wr_valid,
  output logic [SLOT_WIDTH-1:0] slot_wr_ptr,
  output logic [ADDR_WIDTH-1:0] slot_wr_addr,
  output logic [15:0]           slot_wr_len,
  output desc_t                 send_desc,
  output logic                  send_desc_valid,
  input  logic                  send_desc_ready,
  output sched_word_t           ctrl_m_tdata,
  output logic                  ctrl_m_tvalid,
  input  logic                  ctrl_m_tready,
  output logic [63:0]           dram_m_tdata,
  output logic                  dram_m_tvalid,
  input  logic                  dram_m_tready,
  output logic                  dram_m_tlast
);

  dram_rd_state_e drd_state;
  logic           ctrl_load;

  ////////////////////////////////////////////////////////////////////////////
  // Send arbiter, scheduler first
  ////////////////////////////////////////////////////////////////////////////
  assign send_desc        = sched_desc_valid ? sched_desc : data_head;
  assign send_desc_valid  = sched_desc_valid || data_valid;
  assign sched_desc_ready = send_desc_ready;
  assign data_pop         = send_desc_ready && data_valid && !sched_desc_valid;

  ////////////////////////////////////////////////////////////////////////////
  // Control output register
  ////////////////////////////////////////////////////////////////////////////
  assign ctrl_load = ctrl_valid && (!ctrl_m_tvalid || ctrl_m_tready);
  assign ctrl_pop  = ctrl_load;

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      ctrl_m_tvalid <= 1'b0;
    end else if (ctrl_load) begin
      ctrl_m_tvalid <= 1'b1;
    end else if (ctrl_m_tready) begin
      ctrl_m_tvalid <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (ctrl_load) begin
      ctrl_m_tdata <= {ctrl_head[63:60], ctrl_head[31:0]};
    end
  end

  // Same pop updates the parser slot table
  assign slot_wr_valid = ctrl_load;
  assign slot_wr_ptr   = ctrl_head[DESC_SLOT_LSB +: SLOT_WIDTH];
  assign slot_wr_addr  = ctrl_head[DESC_ADDR_LSB +: ADDR_WIDTH];
  assign slot_wr_len   = ctrl_head[DESC_LEN_LSB +: 16];

  ////////////////////////////////////////////////////////////////////////////
  // DRAM read serializer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst || !dram_rd_valid) begin
      drd_state <= DRD_IDLE;
    end else begin
      case (drd_state)
        DRD_IDLE: drd_state <= DRD_DESC;
        DRD_DESC: if (dram_m_tready) drd_state <= DRD_ADDR;
        DRD_ADDR: if (dram_m_tready) drd_state <= DRD_IDLE;
        default:  drd_state <= DRD_IDLE;
      endcase
    end
  end

  // Beat is dropped if the FIFO gets flushed mid request
  assign dram_m_tvalid = (drd_state != DRD_IDLE) && dram_rd_valid;
  assign dram_m_tdata  = (drd_state == DRD_ADDR) ? dram_rd_head[127:64] : dram_rd_head[63:0];
  assign dram_m_tlast  = (drd_state == DRD_ADDR);
  assign dram_rd_pop   = (drd_state == DRD_ADDR) && dram_m_tready;

  a_drd_state_legal: assert property (@(posedge sys_clk) disable iff (sys_rst)
    drd_state inside {DRD_IDLE, DRD_DESC, DRD_ADDR});

endmodule

//--- verilog/sched_msg_parser.sv
/* Scheduler message parser
   Core reset command, per-slot send table and scheduler send descriptors */
module sched_msg_parser
  import hub_desc_pkg::*;
  import sched_msg_pkg::*;
#(
  parameter int ADDR_WIDTH      = 22,
  parameter int SLOT_COUNT      = 8,
  parameter int DESC_DEPTH      = 8,
  parameter int SLOT_START_ADDR = 0,
  parameter int SLOT_ADDR_STEP  = 16384,
  parameter int SLOT_WIDTH      = $clog2(SLOT_COUNT + 1)
) (
  input  logic                  sys_clk,
  input  logic                  sys_rst,
  input  sched_word_t           ctrl_s_tdata,
  input  logic                  ctrl_s_tvalid,
  output logic                  ctrl_s_tready,
  output logic                  core_reset,
  input  logic                  slot_wr_valid,
  input  logic [SLOT_WIDTH-1:0] slot_wr_ptr,
  input  logic [ADDR_WIDTH-1:0] slot_wr_addr,
  input  logic [15:0]           slot_wr_len,
  output desc_t                 sched_desc,
  output logic                  sched_desc_valid,
  input  logic                  sched_desc_ready
);

  logic [ADDR_WIDTH-1:0] slot_addr [1:SLOT_COUNT];
  logic [15:0]           slot_len  [1:SLOT_COUNT];
  sched_word_t           msg_r;
  logic                  msg_valid_r;
  logic                  msg_accept;
  logic                  reset_cmd;
  logic                  fifo_in_ready;
  sched_msg_e            msg_type;
  logic [SLOT_WIDTH-1:0] msg_slot;
  logic [31:0]           msg_addr;
  desc_t                 parsed_desc;

  ////////////////////////////////////////////////////////////////////////////
  // Core reset command
  ////////////////////////////////////////////////////////////////////////////
  assign ctrl_s_tready = !msg_valid_r || fifo_in_ready;
  assign msg_accept    = ctrl_s_tvalid && ctrl_s_tready;
  assign reset_cmd     = msg_accept && (sched_msg_e'(ctrl_s_tdata[35:32]) == MSG_CORE_RESET);

  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      core_reset <= 1'b1;
    end else if (reset_cmd) begin
      core_reset <= ctrl_s_tdata[0];
    end
  end

  // Message stage, dropped while the core sits in reset
  always_ff @(posedge sys_clk) begin
    if (sys_rst || core_reset) begin
      msg_valid_r <= 1'b0;
    end else if (msg_accept) begin
      msg_valid_r <= !reset_cmd;
    end else if (fifo_in_ready) begin
      msg_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (msg_accept) begin
      msg_r <= ctrl_s_tdata;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Slot send table, written by core control descriptors
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge sys_clk) begin
    if (sys_rst) begin
      for (int i = 1; i <= SLOT_COUNT; i++) begin
        slot_addr[i] <= ADDR_WIDTH'(SLOT_START_ADDR + (i - 1) * SLOT_ADDR_STEP);
        slot_len[i]  <= '0;
      end
    end else if (slot_wr_valid) begin
      slot_addr[slot_wr_ptr] <= slot_wr_addr;
      slot_len[slot_wr_ptr]  <= slot_wr_len;
    end
  end

  // Descriptor build
  assign msg_type = sched_msg_e'(msg_r[35:32]);
  assign msg_slot = msg_r[DESC_SLOT_LSB +: SLOT_WIDTH];
  assign msg_addr = {{(32 - ADDR_WIDTH){1'b0}}, slot_addr[msg_slot]};

  always_comb begin
    if (msg_type == MSG_SLOT_SEND) begin
      parsed_desc = {msg_addr, msg_r[31:16], slot_len[msg_slot]};
    end else begin
      parsed_desc = {msg_addr, msg_r[31:0]};
    end
  end

  desc_fifo #(.DEPTH(DESC_DEPTH), .WIDTH(64)) sched_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .clear     (core_reset),
    .din       (parsed_desc),
    .din_valid (msg_valid_r),
    .din_ready (fifo_in_ready),
    .dout      (sched_desc),
    .dout_valid(sched_desc_valid),
    .dout_ready(sched_desc_ready)
  );

  // Scheduler only names slots that the table holds
  a_slot_in_range: assert property (@(posedge sys_clk) disable iff (sys_rst)
    msg_valid_r |-> (msg_slot >= 1) && (msg_slot <= SLOT_COUNT));

endmodule

//--- verilog/core_desc_sorter.sv
/* Core descriptor sorter
   Steers core descriptors by opcode into data, control and DRAM-read FIFOs */
module core_desc_sorter
  import hub_desc_pkg::*;
#(
  parameter int DESC_DEPTH = 8
) (
  input  logic          sys_clk,
  input  logic          sys_rst,
  input  logic          core_reset,
  input  desc_t         core_desc,
  input  logic [63:0]   core_dram_addr,
  input  logic          core_desc_valid,
  output logic          core_desc_ready,
  output desc_t         data_head,
  output logic          data_valid,
  input  logic          data_pop,
  output desc_t         ctrl_head,
  output logic          ctrl_valid,
  input  logic          ctrl_pop,
  output logic [127:0]  dram_rd_head,
  output logic          dram_rd_valid,
  input  logic          dram_rd_pop
);

  desc_op_e op;
  logic     is_data;
  logic     is_ctrl;
  logic     is_dram_rd;
  logic     data_in_ready;
  logic     ctrl_in_ready;
  logic     dram_rd_in_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////
  assign op         = desc_op_e'(core_desc[63:60]);
  assign is_data    = (op == OP_DATA);
  assign is_ctrl    = (op == OP_CTRL_1) || (op == OP_CTRL_2) || (op == OP_CTRL_3);
  assign is_dram_rd = (op == OP_DRAM_RD);

  // DRAM writes and unknown opcodes are swallowed
  always_comb begin
    if (is_data) begin
      core_desc_ready = data_in_ready;
    end else if (is_ctrl) begin
      core_desc_ready = ctrl_in_ready;
    end else if (is_dram_rd) begin
      core_desc_ready = dram_rd_in_ready;
    end else begin
      core_desc_ready = !core_reset;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-type FIFOs, all flushed while the core is held in reset
  ////////////////////////////////////////////////////////////////////////////
  desc_fifo #(.DEPTH(DESC_DEPTH), .WIDTH(64)) data_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .clear     (core_reset),
    .din       (core_desc),
    .din_valid (core_desc_valid && is_data),
    .din_ready (data_in_ready),
    .dout      (data_head),
    .dout_valid(data_valid),
    .dout_ready(data_pop)
  );

  desc_fifo #(.DEPTH(DESC_DEPTH), .WIDTH(64)) ctrl_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .clear     (core_reset),
    .din       (core_desc),
    .din_valid (core_desc_valid && is_ctrl),
    .din_ready (ctrl_in_ready),
    .dout      (ctrl_head),
    .dout_valid(ctrl_valid),
    .dout_ready(ctrl_pop)
  );

  // Address rides above the descriptor
  desc_fifo #(.DEPTH(DESC_DEPTH), .WIDTH(128)) dram_rd_fifo (
    .sys_clk   (sys_clk),
    .sys_rst   (sys_rst),
    .clear     (core_reset),
    .din       ({core_dram_addr, core_desc}),
    .din_valid (core_desc_valid && is_dram_rd),
    .din_ready (dram_rd_in_ready),
    .dout      (dram_rd_head),
    .dout_valid(dram_rd_valid),
    .dout_ready(dram_rd_pop)
  );

  // Core keeps its descriptor steady until it is taken
  a_core_desc_stable: assert property (@(posedge sys_clk) disable iff (sys_rst)
    core_desc_valid && !core_desc_ready |=> $stable(core_desc));

endmodule

//--- verilog/desc_fifo.sv
/* Descriptor FIFO, first-word-fall-through, single clock, with a clear */
module desc_fifo #(
  parameter int DEPTH = 8,
  parameter int WIDTH = 64
) (
  input  logic             sys_clk,
  input  logic             sys_rst,
  input  logic             clear,
  input  logic [WIDTH-1:0] din,
  input  logic             din_valid,
  output logic             din_ready,
  output logic [WIDTH-1:0] dout,
  output logic             dout_valid,
  input  logic             dout_ready
);

  localparam int PTR_WIDTH = $clog2(DEPTH);

  logic [WIDTH-1:0]   mem [DEPTH];
  logic [PTR_WIDTH:0] wr_ptr;
  logic [PTR_WIDTH:0] rd_ptr;
  logic               full;
  logic               empty;
  logic               wr_en;
  logic               rd_en;

  // Extra pointer bit tells full from empty
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[PTR_WIDTH-1:0] == rd_ptr[PTR_WIDTH-1:0]) &&
                 (wr_ptr[PTR_WIDTH] != rd_ptr[PTR_WIDTH]);

  assign din_ready  = !full && !clear;
  assign dout_valid = !empty && !clear;
  assign dout       = mem[rd_ptr[PTR_WIDTH-1:0]];
  assign wr_en      = din_valid && din_ready;
  assign rd_en      = dout_valid && dout_ready;

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      mem[wr_ptr[PTR_WIDTH-1:0]] <= din;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (sys_rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Write side never runs past a full buffer
  a_no_write_when_full: assert property (@(posedge sys_clk) disable iff (sys_rst)
    (PTR_WIDTH + 1)'(wr_ptr - rd_ptr) <= DEPTH);

endmodule

//--- verilog/sched_msg_pkg.sv
/* Scheduler control channel definitions
   36-bit control word with the message type in the top nibble */
package sched_msg_pkg;

  typedef logic [35:0] sched_word_t;

  // Message type lives in bits 35:32, any other value is a plain message
  typedef enum logic [3:0] {
    MSG_SLOT_SEND  = 4'd1,
    MSG_CORE_RESET = 4'd15
  } sched_msg_e;

endpackage

//--- verilog/hub_desc_pkg.sv
/* Descriptor hub definitions
   Core descriptor layout, core opcodes and DRAM-read serializer states */
package hub_desc_pkg;

  // 64-bit descriptor word, opcode sits in bits 63:60
  typedef logic [63:0] desc_t;

  typedef enum logic [3:0] {
    OP_DATA    = 4'd0,
    OP_CTRL_1  = 4'd1,
    OP_CTRL_2  = 4'd2,
    OP_CTRL_3  = 4'd3,
    OP_DRAM_WR = 4'd4,
    OP_DRAM_RD = 4'd5
  } desc_op_e;

  // DRAM read request goes out as descriptor beat then address beat
  typedef enum logic [1:0] {
    DRD_IDLE,
    DRD_DESC,
    DRD_ADDR
  } dram_rd_state_e;

  // Field positions inside a descriptor
  localparam int DESC_LEN_LSB  = 0;
  localparam int DESC_SLOT_LSB = 16;
  localparam int DESC_ADDR_LSB = 32;

endpackage
